// ==== vlane_driver.f ====
+incdir+.
vlane_pkg.sv
vaddr_counter.sv
vbwen_gen.sv
vlane_valid_gen.sv
vseq_fsm.sv
vlane_driver.sv
tb_vlane_driver.sv

// ==== tb_vlane_driver.sv ====
`timescale 1ns/1ns

`include "vlane_settings.svh"

module tb_vlane_driver;

    localparam int RUNS     = 16;      // Instructions issued over all tests
    localparam int RUN_MAX  = 48;      // Worst cycles per instruction, idle check included
    localparam int WATCHDOG = (RUNS * RUN_MAX + 20) * 8 * 2;

    logic                                  clk_i;
    logic                                  rst_i;
    logic                                  start_i;
    logic                                  ready_o;
    vlane_pkg::vl_t                        vl_i;
    vlane_pkg::width_t                     vsew_i;
    logic [1:0]                            wdata_width_i;
    vlane_pkg::inst_type_e                 inst_type_i;
    vlane_pkg::lane_cnt_t                  inst_delay_i;
    logic                                  vector_mask_i;
    vlane_pkg::vrf_addr_t                  vrf_starting_waddr_i;
    vlane_pkg::vrf_addr_t [2:0]            vrf_starting_raddr_i;
    logic                                  load_last_i;
    vlane_pkg::bwen_t [`VLANE_NUM-1:0]     load_bwen_i;
    vlane_pkg::vrf_addr_t [2:0]            vrf_raddr_o;
    vlane_pkg::vrf_addr_t                  vrf_waddr_o;
    vlane_pkg::bwen_t [`VLANE_NUM-1:0]     vrf_bwen_o;
    vlane_pkg::lane_mask_t                 read_data_valid_o;
    vlane_pkg::lane_cnt_t                  vmrf_addr_o;
    logic                                  vmrf_wen_o;
    logic                                  store_data_valid_o;
    logic                                  store_load_index_valid_o;
    logic                                  ready_for_load_o;
    logic                                  request_write_control_o;

    logic [31:0]          seed;
    vlane_pkg::vrf_addr_t waddr_s;        // Start addresses of the current instruction
    vlane_pkg::vrf_addr_t raddr_s [3];

    vlane_driver uut (.*);

    always #4 clk_i = ~clk_i;

    initial begin
        #(WATCHDOG);
        $display("Timeout: the tests did not finish in the expected time");
        $display("FAIL: see errors above");
        $fatal(1, "Watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {8'd0, seed[31:8]};     // Low bits of an LCG are weak
    endfunction

    // Lane l of row k carries element k*lanes + l
    function automatic vlane_pkg::lane_mask_t exp_valid(input int vl, input int k);
        vlane_pkg::lane_mask_t m;
        for (int l = 0; l < `VLANE_NUM; l++) begin
            m[l] = (k * `VLANE_NUM + l) < vl;
        end
        return m;
    endfunction

    // Width code 0 byte, 1 half, 2 word
    function automatic int words_done(input int code, input int k);
        return (code == 0) ? k / 4 : (code == 1) ? k / 2 : k;
    endfunction

    function automatic vlane_pkg::bwen_t exp_pattern(input int ww, input int j);
        case (ww)
            1:       return 4'b0001 << (j % 4);
            2:       return (j % 2 == 1) ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_idle();
        check("ready_o", ready_o, 1);
        check("vrf_bwen_o", vrf_bwen_o, 0);
        check("read_data_valid_o", read_data_valid_o, 0);
        check("vmrf_wen_o", vmrf_wen_o, 0);
        check("store_data_valid_o", store_data_valid_o, 0);
        check("store_load_index_valid_o", store_load_index_valid_o, 0);
        check("ready_for_load_o", ready_for_load_o, 0);
        check("request_write_control_o", request_write_control_o, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // Instruction drivers
    ////////////////////////////////////////////////////////////

    // Returns in the cycle between E0 and E1
    task automatic issue(input vlane_pkg::inst_type_e t, input int vl, input int delay,
                         input logic mask, input int vsew, input int ww);
        @(posedge clk_i);
        waddr_s = vlane_pkg::vrf_addr_t'(next_rand());
        for (int p = 0; p < 3; p++) begin
            raddr_s[p] = vlane_pkg::vrf_addr_t'(next_rand());
            vrf_starting_raddr_i[p] <= raddr_s[p];
        end
        vrf_starting_waddr_i <= waddr_s;
        start_i       <= 1'b1;
        inst_type_i   <= t;
        vl_i          <= vlane_pkg::vl_t'(vl);
        inst_delay_i  <= vlane_pkg::lane_cnt_t'(delay);
        vector_mask_i <= mask;
        vsew_i        <= vlane_pkg::width_t'(vsew);
        wdata_width_i <= 2'(ww);
        @(negedge clk_i);
        check("ready_o", ready_o, 1);
        @(posedge clk_i);
        start_i <= 1'b0;                 // E0, accepted here
        // Later input changes must not reach the running instruction
        vl_i                 <= ~vl_i;
        vsew_i               <= vsew_i + 2'd1;
        wdata_width_i        <= ~wdata_width_i;
        inst_delay_i         <= ~inst_delay_i;
        vector_mask_i        <= ~vector_mask_i;
        vrf_starting_waddr_i <= ~vrf_starting_waddr_i;
        vrf_starting_raddr_i <= ~vrf_starting_raddr_i;
        @(negedge clk_i);
        check("ready_o", ready_o, 0);
    endtask

    // Normal and the three read modes share the read side
    task automatic run_mode(input vlane_pkg::inst_type_e t, input int vl, input int delay,
                            input logic mask, input int vsew, input int ww);
        int   r;
        int   len;
        int   j;
        logic win;
        logic sdv;
        logic sliv;
        r    = (vl + `VLANE_NUM - 1) / `VLANE_NUM;
        len  = (t == vlane_pkg::NORMAL) ? delay + r : r;
        sdv  = (t == vlane_pkg::STORE) || (t == vlane_pkg::INDEXED_STORE);
        sliv = (t == vlane_pkg::INDEXED_STORE) || (t == vlane_pkg::INDEXED_LOAD);
        issue(t, vl, delay, mask, vsew, ww);
        for (int k = 0; k < len; k++) begin
            @(negedge clk_i);
            win = (t == vlane_pkg::NORMAL) && (k >= delay);
            j   = win ? k - delay : 0;
            for (int p = 0; p < 3; p++) begin
                check($sformatf("vrf_raddr_o[%0d]", p), vrf_raddr_o[p],
                      vlane_pkg::vrf_addr_t'(raddr_s[p] + words_done(vsew, k)));
            end
            check("read_data_valid_o", read_data_valid_o, (k < r) ? exp_valid(vl, k) : '0);
            check("vrf_bwen_o", vrf_bwen_o, win ? {`VLANE_NUM{exp_pattern(ww, j)}} : '0);
            check("vrf_waddr_o", vrf_waddr_o,
                  vlane_pkg::vrf_addr_t'(waddr_s + (win ? words_done(ww - 1, j) : 0)));
            check("vmrf_addr_o", vmrf_addr_o, j);
            check("vmrf_wen_o", vmrf_wen_o, win & mask);
            check("store_data_valid_o", store_data_valid_o, sdv);
            check("store_load_index_valid_o", store_load_index_valid_o, sliv);
            check("ready_o", ready_o, 0);
        end
        @(negedge clk_i);
        check_idle();                    // Ready again right after the last mode cycle
    endtask

    task automatic run_load(input int beats);
        issue(vlane_pkg::LOAD, 1 + next_rand() % 64, 0, 1'b0, 2, 3);
        for (int k = 0; k < beats; k++) begin
            @(posedge clk_i);
            load_bwen_i <= next_rand();
            load_last_i <= (k == beats - 1);
            @(negedge clk_i);
            check("ready_for_load_o", ready_for_load_o, 1);
            check("request_write_control_o", request_write_control_o, 1);
            check("vrf_bwen_o", vrf_bwen_o, load_bwen_i);
            check("vrf_waddr_o", vrf_waddr_o, vlane_pkg::vrf_addr_t'(waddr_s + k));
            check("read_data_valid_o", read_data_valid_o, 0);
            check("ready_o", ready_o, 0);
        end
        @(posedge clk_i);
        load_last_i <= 1'b0;
        load_bwen_i <= '0;
        @(negedge clk_i);
        check_idle();
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_ready();
        check_idle();
        run_mode(vlane_pkg::NORMAL, 8, 1, 1'b1, 2, 3);   // Ready falls and returns
    endtask

    task automatic test_normal_word();
        repeat (4) begin
            run_mode(vlane_pkg::NORMAL, 1 + next_rand() % 200, 1 + next_rand() % 8,
                     (next_rand() % 2) == 1, 2, 3);
        end
    endtask

    task automatic test_byte_half();
        run_mode(vlane_pkg::NORMAL, 40 + next_rand() % 160, 1 + next_rand() % 8, 1'b1, 0, 1);
        run_mode(vlane_pkg::NORMAL, 40 + next_rand() % 160, 1 + next_rand() % 8, 1'b1, 1, 2);
        run_mode(vlane_pkg::NORMAL, 40 + next_rand() % 160, 1 + next_rand() % 8, 1'b0, 0, 2);
        run_mode(vlane_pkg::NORMAL, 40 + next_rand() % 160, 1 + next_rand() % 8, 1'b1, 1, 1);
    endtask

    task automatic test_read_modes();
        vlane_pkg::inst_type_e rd_types [3] = '{vlane_pkg::STORE, vlane_pkg::INDEXED_STORE,
                                                vlane_pkg::INDEXED_LOAD};
        for (int i = 0; i < 3; i++) begin
            // Partial last row
            run_mode(rd_types[i], 8 * (next_rand() % 20) + 1 + next_rand() % 7, 0, 1'b0,
                     next_rand() % 3, 3);
        end
        run_mode(vlane_pkg::STORE, 8 * (1 + next_rand() % 20), 0, 1'b0, 2, 3);
    endtask

    task automatic test_load();
        run_load(1);
        run_load(2 + next_rand() % 14);
        run_load(2 + next_rand() % 14);
    endtask

    initial begin
        clk_i                = 1'b0;
        rst_i                = 1'b0;
        start_i              = 1'b0;
        vl_i                 = '0;
        vsew_i               = '0;
        wdata_width_i        = '0;
        inst_type_i          = vlane_pkg::NORMAL;
        inst_delay_i         = '0;
        vector_mask_i        = 1'b0;
        vrf_starting_waddr_i = '0;
        vrf_starting_raddr_i = '0;
        load_last_i          = 1'b0;
        load_bwen_i          = '0;
        seed                 = 32'h9db21064;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b1;
        @(negedge clk_i);
        test_reset_ready();
        test_normal_word();
        test_byte_half();
        test_read_modes();
        test_load();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== vlane_driver.sv ====
`timescale 1ns/1ns

`include "vlane_settings.svh"

module vlane_driver (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  start_i,
    output logic                                  ready_o,
    input  vlane_pkg::vl_t                        vl_i,
    input  vlane_pkg::width_t                     vsew_i,
    input  logic [1:0]                            wdata_width_i,
    input  vlane_pkg::inst_type_e                 inst_type_i,
    input  vlane_pkg::lane_cnt_t                  inst_delay_i,
    input  logic                                  vector_mask_i,
    input  vlane_pkg::vrf_addr_t                  vrf_starting_waddr_i,
    input  vlane_pkg::vrf_addr_t [2:0]            vrf_starting_raddr_i,
    input  logic                                  load_last_i,
    input  vlane_pkg::bwen_t [`VLANE_NUM-1:0]     load_bwen_i,
    output vlane_pkg::vrf_addr_t [2:0]            vrf_raddr_o,
    output vlane_pkg::vrf_addr_t                  vrf_waddr_o,
    output vlane_pkg::bwen_t [`VLANE_NUM-1:0]     vrf_bwen_o,
    output vlane_pkg::lane_mask_t                 read_data_valid_o,
    output vlane_pkg::lane_cnt_t                  vmrf_addr_o,
    output logic                                  vmrf_wen_o,
    output logic                                  store_data_valid_o,
    output logic                                  store_load_index_valid_o,
    output logic                                  ready_for_load_o,
    output logic                                  request_write_control_o
);

    logic              load;
    logic              rd_step;
    logic              wr_en;
    logic              ld_mode;
    logic              word_done;
    logic              wr_step;
    vlane_pkg::bwen_t  gen_bwen;
    vlane_pkg::width_t vsew_q;
    logic [1:0]        wdata_width_q;

    // Widths held for the whole instruction
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            vsew_q        <= '0;
            wdata_width_q <= '0;
        end else if (load) begin
            vsew_q        <= vsew_i;
            wdata_width_q <= wdata_width_i;
        end
    end

    vseq_fsm u_seq (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i),
        .inst_type_i(inst_type_i), .inst_delay_i(inst_delay_i), .vl_i(vl_i),
        .vector_mask_i(vector_mask_i), .load_last_i(load_last_i),
        .ready_o(ready_o), .load_o(load), .rd_step_o(rd_step), .wr_en_o(wr_en),
        .ld_mode_o(ld_mode), .vmrf_addr_o(vmrf_addr_o), .vmrf_wen_o(vmrf_wen_o),
        .store_data_valid_o(store_data_valid_o),
        .store_load_index_valid_o(store_load_index_valid_o),
        .ready_for_load_o(ready_for_load_o),
        .request_write_control_o(request_write_control_o)
    );

    ////////////////////////////////////////////////////////////
    // Address counters
    ////////////////////////////////////////////////////////////

    for (genvar p = 0; p < 3; p++) begin : g_raddr
        vaddr_counter u_raddr (
            .clk_i(clk_i), .rst_i(rst_i), .load_i(load),
            .start_addr_i(vrf_starting_raddr_i[p]), .width_i(vsew_q),
            .step_i(rd_step), .addr_o(vrf_raddr_o[p])
        );
    end

    assign wr_step = ld_mode | word_done;   // Loads write one word per beat

    vaddr_counter u_waddr (
        .clk_i(clk_i), .rst_i(rst_i), .load_i(load),
        .start_addr_i(vrf_starting_waddr_i), .width_i(2'd2),
        .step_i(wr_step), .addr_o(vrf_waddr_o)
    );

    ////////////////////////////////////////////////////////////
    // Byte enables and read valids
    ////////////////////////////////////////////////////////////

    vbwen_gen u_bwen (
        .clk_i(clk_i), .rst_i(rst_i), .en_i(wr_en), .wdata_width_i(wdata_width_q),
        .bwen_o(gen_bwen), .word_done_o(word_done)
    );

    always_comb begin
        for (int l = 0; l < `VLANE_NUM; l++) begin
            vrf_bwen_o[l] = ld_mode ? load_bwen_i[l] : gen_bwen;
        end
    end

    vlane_valid_gen u_valid (
        .clk_i(clk_i), .rst_i(rst_i), .load_i(load), .vl_i(vl_i),
        .shift_i(rd_step), .valid_o(read_data_valid_o)
    );

endmodule

// ==== vseq_fsm.sv ====
`timescale 1ns/1ns

`include "vlane_settings.svh"

module vseq_fsm (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   start_i,
    input  vlane_pkg::inst_type_e  inst_type_i,
    input  vlane_pkg::lane_cnt_t   inst_delay_i,
    input  vlane_pkg::vl_t         vl_i,
    input  logic                   vector_mask_i,
    input  logic                   load_last_i,
    output logic                   ready_o,
    output logic                   load_o,
    output logic                   rd_step_o,
    output logic                   wr_en_o,
    output logic                   ld_mode_o,
    output vlane_pkg::lane_cnt_t   vmrf_addr_o,
    output logic                   vmrf_wen_o,
    output logic                   store_data_valid_o,
    output logic                   store_load_index_valid_o,
    output logic                   ready_for_load_o,
    output logic                   request_write_control_o
);

    localparam int LANE_BITS = $clog2(`VLANE_NUM);
    localparam int CNT_W     = $bits(vlane_pkg::lane_cnt_t) + 1;  // Delay plus read limit

    vlane_pkg::seq_state_e state_q, next_state;
    vlane_pkg::inst_type_e type_q;
    vlane_pkg::lane_cnt_t  inst_delay_q;
    vlane_pkg::lane_cnt_t  rlimit_q;
    vlane_pkg::lane_cnt_t  rlimit;
    vlane_pkg::lane_cnt_t  mask_cnt;
    logic                  mask_q;
    logic                  pending_q;     // Accepted, mode not entered yet
    logic                  accept;
    logic [CNT_W-1:0]      main_cnt;
    logic [CNT_W-1:0]      normal_last;
    logic [CNT_W-1:0]      read_last;

    ////////////////////////////////////////////////////////////
    // Acceptance and capture
    ////////////////////////////////////////////////////////////

    assign accept = start_i & ready_o;
    assign load_o = accept;

    // ceil(vl / lanes)
    assign rlimit = vlane_pkg::lane_cnt_t'(vl_i >> LANE_BITS)
                  + vlane_pkg::lane_cnt_t'(|vl_i[LANE_BITS-1:0]);

    always_ff @(posedge clk_i) begin
        if (accept) begin
            type_q       <= inst_type_i;
            inst_delay_q <= inst_delay_i;
            mask_q       <= vector_mask_i;
            rlimit_q     <= rlimit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            pending_q <= 1'b0;
            ready_o   <= 1'b1;
        end else begin
            pending_q <= accept;
            if (accept) begin
                ready_o <= 1'b0;
            end else if ((state_q != vlane_pkg::IDLE || pending_q) &&
                         next_state == vlane_pkg::IDLE) begin
                ready_o <= 1'b1;     // Mode done or type rejected
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Counters
    ////////////////////////////////////////////////////////////

    assign normal_last = {1'b0, inst_delay_q} + {1'b0, rlimit_q} - 1'b1;
    assign read_last   = {1'b0, rlimit_q} - 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            main_cnt <= '0;
            mask_cnt <= '0;
        end else if (state_q == vlane_pkg::IDLE) begin
            main_cnt <= '0;
            mask_cnt <= '0;
        end else begin
            main_cnt <= main_cnt + 1'b1;     // One per mode cycle
            if (wr_en_o) begin
                mask_cnt <= mask_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= vlane_pkg::IDLE;
        end else begin
            state_q <= next_state;
        end
    end

    always_comb begin
        next_state = state_q;
        case (state_q)
            vlane_pkg::IDLE: begin
                if (pending_q) begin
                    case (type_q)
                        vlane_pkg::NORMAL:        next_state = vlane_pkg::NORMAL_MODE;
                        vlane_pkg::STORE,
                        vlane_pkg::INDEXED_STORE,
                        vlane_pkg::INDEXED_LOAD:  next_state = vlane_pkg::READ_MODE;
                        vlane_pkg::LOAD:          next_state = vlane_pkg::LOAD_MODE;
                        default:                  next_state = vlane_pkg::IDLE;
                    endcase
                end
            end
            vlane_pkg::NORMAL_MODE: begin
                if (main_cnt == normal_last) begin
                    next_state = vlane_pkg::IDLE;
                end
            end
            vlane_pkg::READ_MODE: begin
                if (main_cnt == read_last) begin
                    next_state = vlane_pkg::IDLE;
                end
            end
            vlane_pkg::LOAD_MODE: begin
                if (load_last_i) begin
                    next_state = vlane_pkg::IDLE;   // Last beat written this cycle
                end
            end
            default: next_state = vlane_pkg::IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    assign rd_step_o = (state_q == vlane_pkg::NORMAL_MODE) ||
                       (state_q == vlane_pkg::READ_MODE);
    assign wr_en_o   = (state_q == vlane_pkg::NORMAL_MODE) &&
                       (main_cnt >= {1'b0, inst_delay_q});
    assign ld_mode_o = (state_q == vlane_pkg::LOAD_MODE);

    assign vmrf_addr_o = mask_cnt;
    assign vmrf_wen_o  = wr_en_o & mask_q;

    assign store_data_valid_o = (state_q == vlane_pkg::READ_MODE) &&
                                (type_q == vlane_pkg::STORE ||
                                 type_q == vlane_pkg::INDEXED_STORE);
    assign store_load_index_valid_o = (state_q == vlane_pkg::READ_MODE) &&
                                      (type_q == vlane_pkg::INDEXED_STORE ||
                                       type_q == vlane_pkg::INDEXED_LOAD);

    assign ready_for_load_o        = ld_mode_o;
    assign request_write_control_o = ld_mode_o;   // Load unit owns the write data

    // Only an idle sequencer with nothing in flight may take a start
    a_no_busy_accept : assert property (@(posedge clk_i) disable iff (!rst_i)
        accept |-> (state_q == vlane_pkg::IDLE && !pending_q));

    a_no_reserved_type : assert property (@(posedge clk_i) disable iff (!rst_i)
        accept |=> !(type_q inside {vlane_pkg::REDUCTION, vlane_pkg::SLIDE}));

endmodule

// ==== vlane_valid_gen.sv ====
`timescale 1ns/1ns

`include "vlane_settings.svh"

module vlane_valid_gen (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  load_i,
    input  vlane_pkg::vl_t        vl_i,
    input  logic                  shift_i,
    output vlane_pkg::lane_mask_t valid_o
);

    localparam vlane_pkg::vl_t LANES = `VLANE_NUM;

    vlane_pkg::vl_t remain_q;   // Elements not yet issued to the lanes

    ////////////////////////////////////////////////////////////
    // Remaining length, one row of lanes per shift
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            remain_q <= '0;
        end else if (load_i) begin
            remain_q <= vl_i;
        end else if (shift_i) begin
            if (remain_q > LANES) begin
                remain_q <= remain_q - LANES;
            end else begin
                remain_q <= '0;     // Partial or empty last row
            end
        end
    end

    // Lane l valid while its index is below the remainder
    always_comb begin
        for (int l = 0; l < `VLANE_NUM; l++) begin
            valid_o[l] = shift_i && (vlane_pkg::vl_t'(l) < remain_q);
        end
    end

endmodule

// ==== vbwen_gen.sv ====
`timescale 1ns/1ns

module vbwen_gen (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              en_i,
    input  logic [1:0]        wdata_width_i,   // 1 byte, 2 half, 3 word
    output vlane_pkg::bwen_t  bwen_o,
    output logic              word_done_o
);

    logic [3:0]       shift4_q;
    logic [1:0]       shift2_q;
    vlane_pkg::bwen_t pattern;
    logic             last;

    ////////////////////////////////////////////////////////////
    // Rotating patterns
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            shift4_q <= 4'b0001;
            shift2_q <= 2'b01;
        end else if (en_i) begin
            shift4_q <= {shift4_q[2:0], shift4_q[3]};
            shift2_q <= {shift2_q[0], shift2_q[1]};
        end else begin
            // Next window starts from the low byte again
            shift4_q <= 4'b0001;
            shift2_q <= 2'b01;
        end
    end

    always_comb begin
        case (wdata_width_i)
            2'd1: begin
                pattern = shift4_q;
                last    = shift4_q[3];
            end
            2'd2: begin
                pattern = {{2{shift2_q[1]}}, {2{shift2_q[0]}}};
                last    = shift2_q[1];
            end
            2'd3: begin
                pattern = 4'b1111;
                last    = 1'b1;
            end
            default: begin
                pattern = '0;
                last    = 1'b0;
            end
        endcase
    end

    assign bwen_o      = en_i ? pattern : '0;
    assign word_done_o = en_i & last;   // Steps the write address

    a_byte_onehot : assert property (@(posedge clk_i) disable iff (!rst_i)
        (wdata_width_i == 2'd1) |-> $onehot0(bwen_o));

endmodule

// ==== vaddr_counter.sv ====
`timescale 1ns/1ns

module vaddr_counter (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  load_i,
    input  vlane_pkg::vrf_addr_t  start_addr_i,
    input  vlane_pkg::width_t     width_i,
    input  logic                  step_i,
    output vlane_pkg::vrf_addr_t  addr_o
);

    ////////////////////////////////////////////////////////////
    // Word address and element position inside the word
    ////////////////////////////////////////////////////////////

    vlane_pkg::vrf_addr_t addr_q;
    logic [1:0]           sub_q;     // Elements already taken from this word
    logic                 wrap;

    // Last element of the word reached for this width
    always_comb begin
        case (width_i)
            2'd0:    wrap = (sub_q == 2'd3);  // Four bytes
            2'd1:    wrap = sub_q[0];         // Two halfwords
            default: wrap = 1'b1;             // One word
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_q <= '0;
            sub_q  <= '0;
        end else if (load_i) begin
            addr_q <= start_addr_i;
            sub_q  <= '0;
        end else if (step_i) begin
            if (wrap) begin
                sub_q  <= '0;
                addr_q <= addr_q + 1'b1;
            end else begin
                sub_q <= sub_q + 2'd1;
            end
        end
    end

    assign addr_o = addr_q;

endmodule

// ==== vlane_pkg.sv ====
`include "vlane_settings.svh"

package vlane_pkg;

    ////////////////////////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////////////////////////

    typedef logic [$clog2(`VLANE_MEM_DEPTH)-1:0] vrf_addr_t;   // One VRF word address
    typedef logic [$clog2(`VLANE_NUM*`VLANE_MAX_VL_PER_LANE)-1:0] vl_t;
    typedef logic [$clog2(`VLANE_MAX_VL_PER_LANE):0] lane_cnt_t; // Spare bit on top
    typedef logic [3:0] bwen_t;                                 // Bytes of a 32-bit word
    typedef logic [`VLANE_NUM-1:0] lane_mask_t;

    // Element width code, 0 byte, 1 halfword, 2 word
    typedef logic [1:0] width_t;

    ////////////////////////////////////////////////////////////
    // Enums
    ////////////////////////////////////////////////////////////

    // Encoding follows the issue stage, reduction and slide reserved
    typedef enum logic [$clog2(`VLANE_INST_TYPE_NUM)-1:0] {
        NORMAL,
        REDUCTION,
        STORE,
        INDEXED_STORE,
        LOAD,
        INDEXED_LOAD,
        SLIDE
    } inst_type_e;

    typedef enum logic [1:0] {
        IDLE,
        NORMAL_MODE,
        READ_MODE,
        LOAD_MODE
    } seq_state_e;

endpackage

// ==== vlane_settings.svh ====
`ifndef VLANE_SETTINGS_SVH
`define VLANE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Lane group geometry
////////////////////////////////////////////////////////////

// Lanes served by one sequencer
`define VLANE_NUM 8

// VRF words per lane
`define VLANE_MEM_DEPTH 512

// Most elements one lane can hold
`define VLANE_MAX_VL_PER_LANE 256

////////////////////////////////////////////////////////////
// Instruction decode
////////////////////////////////////////////////////////////

// Instruction type count, reserved types included
`define VLANE_INST_TYPE_NUM 7

`endif
